// ==== common/node_macros.svh ====
`ifndef NODE_MACROS_SVH
`define NODE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory geometry.
`define WORD_WIDTH 16
`define ADDR_WIDTH 11

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed locations in the node memory.
// the low byte of the own q word holds the node's q value.
`define OWN_Q_ADDR 0
`define FLAG_ADDR 2
`define RNG_ADDR 2046
`define Q_TABLE_BASE 16
`define MEMBER_TABLE_BASE 32
`define TABLE_LEN 8

// action codes, both above any node id (ids stay below 64).
`define NO_SINK 65
`define SELF_HOP 300
`define LFSR_SEED 16'hACE1

`endif

// ==== common/mem_pkg.sv ====
`include "node_macros.svh"

package mem_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// one access on either memory port.
	typedef struct packed {
		logic wr_en;
		addr_t address;
		word_t data;
	} mem_req_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// two readings of one table word.
	typedef struct packed {
		logic [7:0] q_value; // larger is better.
		logic [7:0] node_id;
	} q_entry_t;

	typedef struct packed {
		logic is_sink;
		logic same_cluster;
		logic [5:0] hop_count;
		logic [7:0] node_id;
	} member_entry_t;

	typedef union packed {
		q_entry_t q_entry; // words of the q table.
		member_entry_t member_entry; // words of the membership table.
	} table_word_u;

endpackage

// ==== common/route_pkg.sv ====
`include "node_macros.svh"

package route_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// which block owns the engine port.
	typedef enum logic [2:0] {
		idle        = 3'd0, // nothing run since reset.
		best_hop    = 3'd1, // q table scan.
		next_sink   = 3'd2, // membership scan.
		action_load = 3'd3, // select block takes nexthop.
		action_run  = 3'd4, // select block writes flag and random word.
		finish      = 3'd5  // decision held for the host.
	} engine_phase_t;

	// final result of one run.
	typedef struct packed {
		logic [`WORD_WIDTH-1:0] action; // neighbour id, sink id or the self code.
		logic for_aggregation;
	} decision_t;

endpackage

// ==== routing/find_best_hop.sv ====
`timescale 1ns/1ns
`include "node_macros.svh"

module find_best_hop import mem_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic start,
	output logic [`ADDR_WIDTH-1:0] mem_address,
	input table_word_u mem_data,
	output logic [`WORD_WIDTH-1:0] nexthop,
	output logic done
);

	localparam logic [3:0] last_step = 4'(`TABLE_LEN + 2);
	localparam addr_t own_q_addr = `OWN_Q_ADDR;
	localparam addr_t q_base = `Q_TABLE_BASE;
	localparam word_t self_hop = `SELF_HOP;

	logic scanning;
	logic [3:0] step;
	logic [7:0] own_q;
	logic [7:0] best_q;
	logic [7:0] best_id;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address side. step 0 reads the own q word, then one entry per step.
	always_comb begin
		if (step == 4'd0) begin
			mem_address = own_q_addr;
		end else begin
			mem_address = q_base + addr_t'(step) - addr_t'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			scanning <= 1'b0;
			step <= 4'd0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				scanning <= 1'b1;
				step <= 4'd0;
			end else if (scanning) begin
				step <= step + 4'd1;
				if (step == last_step) begin
					scanning <= 1'b0; // result is ready with this pulse.
					done <= 1'b1;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data side. the word on mem_data belongs to the address of the previous step.
	always_ff @(posedge clock) begin
		if (scanning) begin
			if (step == 4'd1) begin
				own_q <= mem_data[7:0]; // the own q sits in the low byte.
			end else if (step == 4'd2) begin
				best_q <= mem_data.q_entry.q_value; // entry 0 starts the search.
				best_id <= mem_data.q_entry.node_id;
			end else if (step > 4'd2 && step < last_step) begin
				if (mem_data.q_entry.q_value > best_q) begin
					best_q <= mem_data.q_entry.q_value; // strictly greater, so ties keep the lower index.
					best_id <= mem_data.q_entry.node_id;
				end
			end else if (step == last_step) begin
				nexthop <= (own_q >= best_q) ? self_hop : word_t'(best_id);
			end
		end
	end

	// the sequencer issues one start per run and waits for done.
	assert property (@(posedge clock) disable iff (!nrst) scanning |-> !start);

endmodule

// ==== routing/find_next_sink.sv ====
`timescale 1ns/1ns
`include "node_macros.svh"

module find_next_sink import mem_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic start,
	output logic [`ADDR_WIDTH-1:0] mem_address,
	input table_word_u mem_data,
	output logic [`WORD_WIDTH-1:0] nextsinks,
	output logic done
);

	localparam logic [3:0] last_step = 4'(`TABLE_LEN + 2);
	localparam logic [3:0] table_len = 4'(`TABLE_LEN);
	localparam logic [3:0] last_entry = 4'(`TABLE_LEN - 1);
	localparam addr_t member_base = `MEMBER_TABLE_BASE;
	localparam word_t no_sink = `NO_SINK;

	logic scanning;
	logic found;
	logic [3:0] step;
	logic [3:0] rd_idx;
	logic [7:0] sink_id;
	logic match;

	assign mem_address = member_base + addr_t'(rd_idx);

	// a valid entry is on the bus from step 1 to step TABLE_LEN.
	assign match = (step != 4'd0) && (step <= table_len) &&
		mem_data.member_entry.is_sink && mem_data.member_entry.same_cluster;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock) begin
		if (!nrst) begin
			scanning <= 1'b0;
			found <= 1'b0;
			step <= 4'd0;
			rd_idx <= 4'd0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				scanning <= 1'b1;
				found <= 1'b0;
				step <= 4'd0;
				rd_idx <= 4'd0;
			end else if (scanning) begin
				step <= step + 4'd1;
				if (!found && rd_idx != last_entry) begin
					rd_idx <= rd_idx + 4'd1; // address freezes once a sink is found.
				end
				if (!found && match) begin
					found <= 1'b1; // first matching entry wins.
					sink_id <= mem_data.member_entry.node_id;
				end
				if (step == last_step) begin
					scanning <= 1'b0; // fixed done time even after an early match.
					done <= 1'b1;
					nextsinks <= found ? word_t'(sink_id) : no_sink;
				end
			end
		end
	end

endmodule

// ==== routing/select_my_action.sv ====
`timescale 1ns/1ns
`include "node_macros.svh"

module select_my_action import mem_pkg::*, route_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic en,
	input logic start,
	input logic [`WORD_WIDTH-1:0] nexthop,
	input logic [`WORD_WIDTH-1:0] nextsinks,
	input logic [`WORD_WIDTH-1:0] rng_in,
	output mem_req_t mem_req,
	output decision_t decision,
	output logic rng_take,
	output logic done
);

	localparam word_t no_sink = `NO_SINK;
	localparam word_t self_hop = `SELF_HOP;
	localparam addr_t flag_addr = `FLAG_ADDR;
	localparam addr_t rng_addr = `RNG_ADDR;

	logic [2:0] state;
	word_t action;
	logic for_aggregation;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// 0 waits for start, 1 picks the sink, 2 writes the flag,
	// 3 writes the random word, 4 settles, 5 raises done, 6 waits for en.
	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= 3'd6;
			done <= 1'b0;
			for_aggregation <= 1'b0;
			mem_req.wr_en <= 1'b0;
			rng_take <= 1'b0;
		end else begin
			mem_req.wr_en <= 1'b0; // writes are single-cycle pulses.
			rng_take <= 1'b0;
			case (state)
				3'd0: begin
					if (start) begin
						state <= 3'd1;
					end
				end
				3'd1: begin
					if (nextsinks != no_sink) begin
						action <= nextsinks; // a sink in our cluster beats the best hop.
					end
					state <= 3'd2;
				end
				3'd2: begin
					if (action == self_hop) begin
						for_aggregation <= 1'b1; // no better head nearby, so aggregate here.
						mem_req.address <= flag_addr;
						mem_req.data <= word_t'(1);
						mem_req.wr_en <= 1'b1;
					end else begin
						for_aggregation <= 1'b0;
					end
					state <= 3'd3;
				end
				3'd3: begin
					mem_req.address <= rng_addr; // seed for later explore hops.
					mem_req.data <= rng_in;
					mem_req.wr_en <= 1'b1;
					rng_take <= 1'b1;
					state <= 3'd4;
				end
				3'd4: begin
					state <= 3'd5;
				end
				3'd5: begin
					done <= 1'b1;
					state <= 3'd6;
				end
				3'd6: begin
					if (en) begin
						done <= 1'b0;
						for_aggregation <= 1'b0;
						action <= nexthop;
						state <= 3'd0;
					end
				end
				default: begin
					state <= 3'd5;
				end
			endcase
		end
	end

	assign decision.action = action;
	assign decision.for_aggregation = for_aggregation;

	// flag and random word writes are over before done rises.
	assert property (@(posedge clock) disable iff (!nrst) mem_req.wr_en |-> ##2 !mem_req.wr_en);
	assert property (@(posedge clock) disable iff (!nrst) (state == 3'd7) |=> (state == 3'd5));

endmodule

// ==== source/rng_lfsr.sv ====
`timescale 1ns/1ns
`include "node_macros.svh"

module rng_lfsr (
	input logic clock,
	input logic nrst,
	input logic take,
	output logic [`WORD_WIDTH-1:0] value
);

	localparam logic [`WORD_WIDTH-1:0] taps = 16'hB400;

	logic [`WORD_WIDTH-1:0] next_value;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// galois form, shifting right and folding the dropped bit into the taps.
	always_comb begin
		next_value = value >> 1;
		if (value[0]) begin
			next_value = next_value ^ taps;
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			value <= `LFSR_SEED;
		end else if (take) begin
			value <= next_value; // one step per consumed word.
		end
	end

	// a zero state would lock the sequence for good.
	assert property (@(posedge clock) disable iff (!nrst) value != '0);

endmodule

// ==== source/node_memory.sv ====
`timescale 1ns/1ns
`include "node_macros.svh"

module node_memory import mem_pkg::*; (
	input logic clock,
	input mem_req_t engine_req,
	output table_word_u engine_data,
	input mem_req_t host_req,
	output logic [`WORD_WIDTH-1:0] host_data,
	input logic busy
);

	word_t mem [0:(1 << `ADDR_WIDTH) - 1];

	always_ff @(posedge clock) begin
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// engine port. the scanners read here, the select block writes.
		if (engine_req.wr_en) begin
			mem[engine_req.address] <= engine_req.data;
		end
		engine_data <= mem[engine_req.address]; // data follows the address by one cycle.

		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// host port. tables are loaded and results read back here.
		if (host_req.wr_en) begin
			mem[host_req.address] <= host_req.data;
		end
		host_data <= mem[host_req.address];
	end

	// the host leaves the tables alone while the engine runs.
	assert property (@(posedge clock) host_req.wr_en |-> !busy);

endmodule

// ==== source/route_engine_top.sv ====
`timescale 1ns/1ns
`include "node_macros.svh"

module route_engine_top import mem_pkg::*, route_pkg::*; (
	input logic clock,
	input logic nrst,
	input logic start,
	input mem_req_t host_req,
	output logic [`WORD_WIDTH-1:0] host_read_data,
	output logic busy,
	output logic done,
	output decision_t decision
);

	engine_phase_t phase;
	logic best_start;
	logic best_done;
	logic sink_start;
	logic sink_done;
	logic sel_en;
	logic sel_start;
	logic sel_done;
	logic rng_take;
	addr_t best_address;
	addr_t sink_address;
	word_t nexthop;
	word_t nextsinks;
	word_t rng_value;
	mem_req_t sel_req;
	mem_req_t engine_req;
	table_word_u engine_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// phase sequencer. each step is kicked off by a one-cycle pulse.
	always_ff @(posedge clock) begin
		if (!nrst) begin
			phase <= idle;
			best_start <= 1'b0;
			sink_start <= 1'b0;
			sel_en <= 1'b0;
			sel_start <= 1'b0;
		end else begin
			best_start <= 1'b0;
			sink_start <= 1'b0;
			sel_en <= 1'b0;
			sel_start <= 1'b0;
			case (phase)
				idle, finish: begin
					if (start) begin
						phase <= best_hop;
						best_start <= 1'b1;
					end
				end
				best_hop: begin
					if (best_done) begin
						phase <= next_sink;
						sink_start <= 1'b1;
					end
				end
				next_sink: begin
					if (sink_done) begin
						phase <= action_load;
						sel_en <= 1'b1; // select block latches nexthop.
					end
				end
				action_load: begin
					phase <= action_run;
					sel_start <= 1'b1;
				end
				action_run: begin
					if (sel_done) begin
						phase <= finish; // decision stays put until the next start.
					end
				end
				default: begin
					phase <= idle;
				end
			endcase
		end
	end

	assign busy = !(phase inside {idle, finish});
	assign done = (phase == finish);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// engine port goes to whichever block owns the phase. scanners only read.
	always_comb begin
		engine_req = '0;
		case (phase)
			best_hop: engine_req.address = best_address;
			next_sink: engine_req.address = sink_address;
			action_load, action_run: engine_req = sel_req;
			default: engine_req = '0;
		endcase
	end

	find_best_hop best_hop_i (
		.clock(clock),
		.nrst(nrst),
		.start(best_start),
		.mem_address(best_address),
		.mem_data(engine_data),
		.nexthop(nexthop),
		.done(best_done)
	);

	find_next_sink next_sink_i (
		.clock(clock),
		.nrst(nrst),
		.start(sink_start),
		.mem_address(sink_address),
		.mem_data(engine_data),
		.nextsinks(nextsinks),
		.done(sink_done)
	);

	select_my_action select_i (
		.clock(clock),
		.nrst(nrst),
		.en(sel_en),
		.start(sel_start),
		.nexthop(nexthop),
		.nextsinks(nextsinks),
		.rng_in(rng_value),
		.mem_req(sel_req),
		.decision(decision),
		.rng_take(rng_take),
		.done(sel_done)
	);

	rng_lfsr rng_i (
		.clock(clock),
		.nrst(nrst),
		.take(rng_take),
		.value(rng_value)
	);

	node_memory memory_i (
		.clock(clock),
		.engine_req(engine_req),
		.engine_data(engine_data),
		.host_req(host_req),
		.host_data(host_read_data),
		.busy(busy)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clock,
	output logic nrst
);

	localparam int half_period = 50; // 100 ns clock.
	localparam int reset_cycles = 3;

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	initial begin
		nrst = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		nrst <= 1'b1; // released on the edge, like any other stimulus.
	end

endmodule

// ==== tb/route_engine_tb.sv ====
`timescale 1ns/1ns
`include "node_macros.svh"

module route_engine_tb import mem_pkg::*, route_pkg::*; ();

	localparam int directed_tests = 5;
	localparam int random_tests = 40;
	localparam int run_limit = 2 * (`TABLE_LEN + 3) + 20; // cycles from start to done, with margin.
	localparam int cycles_per_test = (2 * `TABLE_LEN + 3) + run_limit + 14;
	localparam int timeout_cycles = 3 + 10 + (directed_tests + random_tests) * cycles_per_test + 20;

	logic clock;
	logic nrst;
	logic start;
	mem_req_t host_req;
	word_t host_read_data;
	logic busy;
	logic done;
	decision_t decision;

	// table contents as the host loads them.
	logic [7:0] own_q;
	logic [7:0] q_value [`TABLE_LEN];
	logic [7:0] q_id [`TABLE_LEN];
	logic member_sink [`TABLE_LEN];
	logic member_cluster [`TABLE_LEN];
	logic [5:0] member_hops [`TABLE_LEN];
	logic [7:0] member_id [`TABLE_LEN];
	word_t flag_host;

	decision_t expected;
	word_t rng_state;
	int error_count;
	int decisions;

	tb_clock_gen clock_gen_i (
		.clock(clock),
		.nrst(nrst)
	);

	route_engine_top dut_i (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.host_req(host_req),
		.host_read_data(host_read_data),
		.busy(busy),
		.done(done),
		.decision(decision)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model.
	function automatic decision_t expected_decision();
		logic [7:0] best_q;
		logic [7:0] best_id;
		logic found;
		decision_t result;
		int i;
		best_q = q_value[0];
		best_id = q_id[0];
		for (i = 1; i < `TABLE_LEN; i++) begin
			if (q_value[i] > best_q) begin
				best_q = q_value[i]; // only a strictly higher value displaces a lower index.
				best_id = q_id[i];
			end
		end
		result.action = (own_q >= best_q) ? 16'(`SELF_HOP) : {8'h00, best_id};
		found = 1'b0;
		for (i = 0; i < `TABLE_LEN; i++) begin
			if (!found && member_sink[i] && member_cluster[i]) begin
				found = 1'b1;
				result.action = {8'h00, member_id[i]}; // first sink of our own cluster.
			end
		end
		result.for_aggregation = (result.action == 16'(`SELF_HOP));
		return result;
	endfunction

	function automatic word_t lfsr_step(input word_t state);
		word_t next_state;
		next_state = state >> 1;
		if (state[0]) begin
			next_state = next_state ^ 16'hB400;
		end
		return next_state;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] wanted,
			input string what);
		if (actual !== wanted) begin
			error_count++;
			$display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
				wanted);
			abort_run();
		end
	endtask

	task automatic host_write(input addr_t address, input word_t data);
		@(posedge clock);
		host_req.wr_en <= 1'b1;
		host_req.address <= address;
		host_req.data <= data;
	endtask

	task automatic host_read(input addr_t address, output word_t data);
		@(posedge clock);
		host_req.wr_en <= 1'b0;
		host_req.address <= address;
		@(posedge clock); // memory registers the word on this edge.
		@(negedge clock);
		data = host_read_data;
	endtask

	task automatic load_tables();
		int i;
		host_write(addr_t'(`OWN_Q_ADDR), {~own_q, own_q}); // only the low byte holds the own q.
		for (i = 0; i < `TABLE_LEN; i++) begin
			host_write(addr_t'(`Q_TABLE_BASE + i), {q_value[i], q_id[i]});
		end
		for (i = 0; i < `TABLE_LEN; i++) begin
			host_write(addr_t'(`MEMBER_TABLE_BASE + i),
				{member_sink[i], member_cluster[i], member_hops[i], member_id[i]});
		end
		host_write(addr_t'(`FLAG_ADDR), flag_host);
		@(posedge clock);
		host_req.wr_en <= 1'b0;
	endtask

	task automatic clear_tables();
		int i;
		own_q = 8'd0;
		for (i = 0; i < `TABLE_LEN; i++) begin
			q_value[i] = 8'd0;
			q_id[i] = 8'(i);
			member_sink[i] = 1'b0;
			member_cluster[i] = 1'b0;
			member_hops[i] = 6'(i + 1);
			member_id[i] = 8'(50 + i);
		end
		flag_host = 16'h00f0;
	endtask

	task automatic set_q_entry(input int index, input logic [7:0] q, input logic [7:0] id);
		q_value[index] = q;
		q_id[index] = id;
	endtask

	task automatic set_member(input int index, input logic sink, input logic cluster,
			input logic [7:0] id);
		member_sink[index] = sink;
		member_cluster[index] = cluster;
		member_id[index] = id;
	endtask

	task automatic random_tables(input int index);
		int i;
		own_q = (index % 4 == 0) ? 8'($urandom_range(24, 40)) : 8'($urandom_range(0, 31));
		for (i = 0; i < `TABLE_LEN; i++) begin
			q_value[i] = 8'($urandom_range(0, 31)); // narrow range so ties turn up.
			q_id[i] = 8'($urandom_range(0, 63));
			member_sink[i] = ($urandom_range(0, 3) == 0);
			member_cluster[i] = ($urandom_range(0, 1) == 1);
			member_hops[i] = 6'($urandom());
			member_id[i] = 8'($urandom_range(0, 63));
		end
		flag_host = 16'($urandom_range(2, 65535));
	endtask

	task automatic wait_for_done();
		int n;
		n = 0;
		@(negedge clock);
		check_value(32'(done), 32'd0, "done clears after start");
		while (!done && n < run_limit) begin
			@(negedge clock);
			n++;
		end
		if (!done) begin
			$display("timeout: done did not rise within %0d cycles of start", run_limit);
			abort_run();
		end
	endtask

	task automatic run_decision(input string name);
		decision_t next_expected;
		word_t word;
		load_tables();
		@(negedge clock);
		check_value(32'(busy), 32'd0, "busy low between runs");
		if (decisions > 0) begin
			check_value(32'(done), 32'd1, "done held until the next start");
		end
		next_expected = expected_decision();
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		expected <= next_expected; // done is low from this edge on.
		wait_for_done();
		host_read(addr_t'(`FLAG_ADDR), word);
		check_value(32'(word), next_expected.for_aggregation ? 32'd1 : 32'(flag_host),
			{name, ": flag word"});
		host_read(addr_t'(`RNG_ADDR), word);
		check_value(32'(word), 32'(rng_state), {name, ": random word"});
		rng_state = lfsr_step(rng_state); // one step per decision.
		repeat (4) @(negedge clock);
		decisions++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decision must match and stay put for as long as done is high.
	always @(negedge clock) begin
		if (nrst && done) begin
			check_value(32'(decision), 32'(expected), "decision while done is high");
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		abort_run();
	end

	initial begin
		int t;
		start = 1'b0;
		host_req = '0;
		error_count = 0;
		decisions = 0;
		expected = '0;
		rng_state = `LFSR_SEED;
		void'($urandom(32'h1cf0));
		wait (nrst === 1'b1);
		repeat (10) begin
			@(negedge clock);
			check_value(32'(done), 32'd0, "done after reset");
			check_value(32'(decision.for_aggregation), 32'd0, "for_aggregation after reset");
			check_value(32'(busy), 32'd0, "busy after reset");
		end

		clear_tables();
		own_q = 8'd5;
		set_q_entry(0, 8'd20, 8'd11);
		set_q_entry(1, 8'd40, 8'd12);
		set_q_entry(2, 8'd90, 8'd13); // ties with entry 5 and must win.
		set_q_entry(3, 8'd60, 8'd14);
		set_q_entry(4, 8'd10, 8'd15);
		set_q_entry(5, 8'd90, 8'd16);
		set_q_entry(6, 8'd30, 8'd17);
		set_q_entry(7, 8'd5, 8'd18);
		set_member(4, 1'b0, 1'b1, 8'd24);
		run_decision("best hop with tie");

		set_member(1, 1'b1, 1'b0, 8'd21); // sink, but in another cluster.
		set_member(2, 1'b0, 1'b1, 8'd22);
		set_member(3, 1'b1, 1'b1, 8'd41);
		set_member(6, 1'b1, 1'b1, 8'd44);
		flag_host = 16'h0a0a;
		run_decision("sink override");

		clear_tables();
		own_q = 8'd200;
		set_q_entry(3, 8'd150, 8'd9);
		run_decision("aggregation, own q above all");

		own_q = 8'd150; // equal to the best neighbour.
		flag_host = 16'h0300;
		run_decision("aggregation, own q equal");

		own_q = 8'd200;
		set_member(5, 1'b1, 1'b1, 8'd33);
		flag_host = 16'h5555;
		run_decision("sink beats aggregation");

		for (t = 0; t < random_tests; t++) begin
			random_tables(t);
			run_decision($sformatf("random decision %0d", t));
		end

		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+common
common/mem_pkg.sv
common/route_pkg.sv
routing/find_best_hop.sv
routing/find_next_sink.sv
routing/select_my_action.sv
source/rng_lfsr.sv
source/node_memory.sv
source/route_engine_top.sv
tb/tb_clock_gen.sv
tb/route_engine_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the routing engine testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 -f project.f \
	--top-module route_engine_tb -o route_engine_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/route_engine_sim > sim.log 2>&1
grep -q "^PASS: all tests$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
